// File: design/phold_defines.svh
`ifndef PHOLD_DEFINES_SVH
`define PHOLD_DEFINES_SVH

// Event word fields
`define PHOLD_TW 16
`define PHOLD_NIDB 3
`define PHOLD_NRB 8
`define PHOLD_OFS_W 8

// Number of logical processes
`define PHOLD_NLP 8

// History store geometry
`define PHOLD_HIST_DEPTH 16
`define PHOLD_HIST_AW 4
`define PHOLD_CNT_W 5

// Rollback buffer
`define PHOLD_RB_DEPTH 16

// Smallest lookahead between an event and the event it schedules
`define PHOLD_MIN_GAP 10

`endif

// File: design/phold_pkg.sv
`include "phold_defines.svh"

package phold_pkg;

   // Event message as it travels between LPs
   typedef struct packed {
      logic [11:0]              pad;     // Always zero
      logic                     cancel;  // 1 marks an anti-message
      logic [`PHOLD_NIDB-1:0]   lp;
      logic [`PHOLD_TW-1:0]     ts;
   } evt_msg_t;

   // Processed event kept in an LP history
   typedef struct packed {
      logic                     pad;
      logic [`PHOLD_NIDB-1:0]   target;  // LP of the event it scheduled
      logic [`PHOLD_OFS_W-1:0]  offset;  // Time gap to the scheduled event
      logic                     cancel;
      logic [`PHOLD_NIDB-1:0]   lp;
      logic [`PHOLD_TW-1:0]     ts;
   } hist_entry_t;

   typedef union packed {
      evt_msg_t    msg;
      hist_entry_t ent;
   } hist_word_u;

   typedef struct packed {
      logic                     valid;
      evt_msg_t                 msg;
      logic [`PHOLD_TW-1:0]     gvt;
      logic [`PHOLD_NRB-1:0]    rnd;
   } evt_in_t;

   typedef struct packed {
      logic     valid;
      evt_msg_t msg;
   } msg_out_t;

   typedef struct packed {
      logic                        en;
      logic [`PHOLD_NIDB-1:0]      lp;
      logic [`PHOLD_HIST_AW-1:0]   idx;
      hist_word_u                  word;
      logic                        cnt_en;
      logic [`PHOLD_CNT_W-1:0]     cnt;
   } hist_wr_t;

   typedef struct packed {
      logic     valid;
      logic     has_main;
      evt_msg_t main;
   } scan_done_t;

endpackage

// File: design/history_store.sv
`include "phold_defines.svh"

module history_store import phold_pkg::*; (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic [`PHOLD_NIDB-1:0]    rd_lp,
   input  logic [`PHOLD_HIST_AW-1:0] rd_idx,
   output hist_word_u                rd_word,
   output logic [`PHOLD_CNT_W-1:0]   cnt,
   input  hist_wr_t                  wr
);

   localparam int NWORDS = `PHOLD_NLP * `PHOLD_HIST_DEPTH;

   hist_word_u                mem [NWORDS];
   logic [`PHOLD_CNT_W-1:0]   cnt_q [`PHOLD_NLP];

   // LP id selects the bank, index the slot within it
   always_ff @(posedge clk) begin
      if (wr.en) begin
         mem[{wr.lp, wr.idx}] <= wr.word;
      end
      rd_word <= mem[{rd_lp, rd_idx}];  // Old data on a same-address write
   end

   // Entry count per LP, updated once per processed event
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `PHOLD_NLP; i++) begin
            cnt_q[i] <= '0;
         end
      end else if (wr.cnt_en) begin
         cnt_q[wr.lp] <= wr.cnt;
      end
   end

   assign cnt = cnt_q[rd_lp];  // Bounds the scan of the selected LP

endmodule

// File: design/history_filter.sv
`include "phold_defines.svh"

module history_filter import phold_pkg::*; (
   input  logic                      clk,
   input  logic                      arst_n,
   input  evt_in_t                   evt,
   output logic                      ready,
   output logic [`PHOLD_NIDB-1:0]    rd_lp,
   output logic [`PHOLD_HIST_AW-1:0] rd_idx,
   input  hist_word_u                rd_word,
   input  logic [`PHOLD_CNT_W-1:0]   cnt,
   output hist_wr_t                  wr,
   output logic                      rb_push,
   output hist_word_u                rb_word,
   output scan_done_t                scan_done,
   input  logic                      seq_done
);

   localparam int CW = `PHOLD_CNT_W;
   localparam int TW = `PHOLD_TW;
   localparam int OW = `PHOLD_OFS_W;
   localparam int AW = `PHOLD_HIST_AW;

   localparam logic [1:0] IDLE   = 2'd0;
   localparam logic [1:0] SCAN   = 2'd1;
   localparam logic [1:0] APPEND = 2'd2;
   localparam logic [1:0] EMIT   = 2'd3;

   logic [1:0]            state;
   evt_msg_t              cur;
   logic [TW-1:0]         gvt;
   logic [`PHOLD_NRB-1:0] rnd;
   logic [CW-1:0]         rd_i;
   logic [CW-1:0]         wr_i;
   logic                  rd_vld;
   logic                  discard;  // Current event was cancelled against an entry
   evt_msg_t              cncl_msg;

   hist_entry_t           ent;
   logic                  issue;
   logic                  expired;
   logic                  match;
   logic                  hit;
   logic                  rollback;
   logic                  keep;
   logic                  do_app;
   logic [OW-1:0]         gen_ofs;
   logic [TW-1:0]         gen_ts;
   hist_entry_t           app_ent;
   evt_msg_t              hit_msg;
   evt_msg_t              null_msg;
   evt_msg_t              new_msg;

   assign ready  = (state == IDLE);
   assign rd_lp  = cur.lp;
   assign rd_idx = rd_i[AW-1:0];
   assign ent    = rd_word.ent;

   // Entry classification, in priority order
   assign issue    = (state == SCAN) && (rd_i < cnt);
   assign expired  = ent.ts < gvt;
   assign match    = (ent.cancel != cur.cancel) && (ent.ts == cur.ts) && !discard;
   assign hit      = rd_vld && !expired && match;
   assign rollback = !cur.cancel && !ent.cancel && (ent.ts > cur.ts);
   assign keep     = rd_vld && !expired && !match && !rollback;

   assign rb_push = rd_vld && !expired && !match && rollback;
   assign rb_word = rd_word;

   // Scheduled event sits at least MIN_GAP ahead
   assign gen_ofs = OW'(`PHOLD_MIN_GAP) + OW'(rnd[4:0]);
   assign gen_ts  = cur.ts + TW'(gen_ofs);
   assign do_app  = (state == APPEND) && !cur.cancel && !discard &&
                    (wr_i < CW'(`PHOLD_HIST_DEPTH));

   always_comb begin
      app_ent        = '0;
      app_ent.target = rnd[`PHOLD_NRB-1:5];
      app_ent.offset = gen_ofs;
      app_ent.lp     = cur.lp;
      app_ent.ts     = cur.ts;
      hit_msg        = '0;
      hit_msg.cancel = 1'b1;
      hit_msg.lp     = ent.target;
      hit_msg.ts     = ent.ts + TW'(ent.offset);  // Undo what the entry scheduled
      new_msg        = '0;
      new_msg.lp     = rnd[`PHOLD_NRB-1:5];
      new_msg.ts     = gen_ts;
      null_msg        = '0;
      null_msg.cancel = 1'b1;
   end

   // Kept entries are compacted in place, then the new entry goes on top
   always_comb begin
      wr     = '0;
      wr.lp  = cur.lp;
      wr.idx = wr_i[AW-1:0];
      if (state == SCAN) begin
         wr.en   = keep;
         wr.word = rd_word;
      end else if (state == APPEND) begin
         wr.en       = do_app;
         wr.word.ent = app_ent;
         wr.cnt_en   = 1'b1;
         wr.cnt      = wr_i + CW'(do_app);
      end
   end

   always_comb begin
      scan_done          = '0;
      scan_done.valid    = (state == APPEND);
      scan_done.has_main = 1'b1;  // Every event yields one main message
      if (discard && cur.cancel) begin
         scan_done.main = cncl_msg;
      end else if (discard || cur.cancel) begin
         scan_done.main = null_msg;
      end else begin
         scan_done.main = new_msg;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= IDLE;
         rd_i    <= '0;
         wr_i    <= '0;
         rd_vld  <= 1'b0;
         discard <= 1'b0;
      end else begin
         rd_vld <= issue;  // Store answers one cycle later
         case (state)
            IDLE: begin
               if (evt.valid) begin
                  state   <= SCAN;
                  rd_i    <= '0;
                  wr_i    <= '0;
                  discard <= 1'b0;
               end
            end
            SCAN: begin
               if (issue) rd_i <= rd_i + 1'b1;
               if (keep) wr_i <= wr_i + 1'b1;
               if (hit) discard <= 1'b1;
               if (!issue && !rd_vld) state <= APPEND;
            end
            APPEND: state <= EMIT;
            EMIT: begin
               if (seq_done) state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (ready && evt.valid) begin
         cur <= evt.msg;
         gvt <= evt.gvt;
         rnd <= evt.rnd;
      end
      if (hit && cur.cancel) begin
         cncl_msg <= hit_msg;
      end
   end

endmodule

// File: design/rollback_fifo.sv
`include "phold_defines.svh"

module rollback_fifo import phold_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       push,
   input  hist_word_u din,
   input  logic       pop,
   output hist_word_u head,
   output logic       empty
);

   localparam int AW = $clog2(`PHOLD_RB_DEPTH);

   hist_word_u mem [`PHOLD_RB_DEPTH];
   logic [AW:0] wr_ptr;  // Extra bit tells full from empty
   logic [AW:0] rd_ptr;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr[AW-1:0]] <= din;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop && !empty) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Oldest entry is visible without a pop
   assign head  = mem[rd_ptr[AW-1:0]];
   assign empty = (wr_ptr == rd_ptr);

endmodule

// File: design/msg_sequencer.sv
`include "phold_defines.svh"

module msg_sequencer import phold_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  scan_done_t scan_done,
   input  hist_word_u head,
   input  logic       empty,
   output logic       pop,
   output msg_out_t   msg_out,
   output logic       seq_done
);

   localparam int TW = `PHOLD_TW;

   localparam logic [1:0] S_IDLE = 2'd0;
   localparam logic [1:0] S_NEXT = 2'd1;  // Cancellation for the head entry
   localparam logic [1:0] S_ROLL = 2'd2;  // Rollback of the head entry

   logic [1:0] state;
   evt_msg_t   cncl_msg;
   evt_msg_t   roll_msg;

   // Anti-message for the event the rolled-back entry scheduled
   always_comb begin
      cncl_msg        = '0;
      cncl_msg.cancel = 1'b1;
      cncl_msg.lp     = head.ent.target;
      cncl_msg.ts     = head.ent.ts + TW'(head.ent.offset);  // Wraps at timestamp width
      roll_msg        = '0;
      roll_msg.lp     = head.msg.lp;
      roll_msg.ts     = head.msg.ts;  // Re-sent as a regular event
   end

   assign pop = (state == S_ROLL);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= S_IDLE;
         msg_out  <= '0;
         seq_done <= 1'b0;
      end else begin
         msg_out.valid <= 1'b0;
         seq_done      <= 1'b0;
         case (state)
            S_IDLE: begin
               if (scan_done.valid) begin
                  state <= S_NEXT;
                  if (scan_done.has_main) begin
                     msg_out.valid <= 1'b1;
                     msg_out.msg   <= scan_done.main;
                  end
               end
            end
            S_NEXT: begin
               if (!empty) begin
                  state         <= S_ROLL;
                  msg_out.valid <= 1'b1;
                  msg_out.msg   <= cncl_msg;
               end else begin
                  state    <= S_IDLE;
                  seq_done <= 1'b1;  // Last message went out last cycle
               end
            end
            S_ROLL: begin
               state         <= S_NEXT;
               msg_out.valid <= 1'b1;
               msg_out.msg   <= roll_msg;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

// File: design/phold_core.sv
`include "phold_defines.svh"

module phold_core import phold_pkg::*; (
   input  logic     clk,
   input  logic     arst_n,
   input  evt_in_t  evt_in,
   output msg_out_t msg_out,
   output logic     ready
);

   logic [`PHOLD_NIDB-1:0]    rd_lp;
   logic [`PHOLD_HIST_AW-1:0] rd_idx;
   hist_word_u                rd_word;
   logic [`PHOLD_CNT_W-1:0]   cnt;
   hist_wr_t                  wr;
   logic                      rb_push;
   hist_word_u                rb_word;
   logic                      rb_pop;
   logic                      rb_empty;
   hist_word_u                rb_head;
   scan_done_t                scan_done;
   logic                      seq_done;

   history_store u_store (
      .clk     (clk),
      .arst_n  (arst_n),
      .rd_lp   (rd_lp),
      .rd_idx  (rd_idx),
      .rd_word (rd_word),
      .cnt     (cnt),
      .wr      (wr)
   );

   history_filter u_filter (
      .clk       (clk),
      .arst_n    (arst_n),
      .evt       (evt_in),
      .ready     (ready),
      .rd_lp     (rd_lp),
      .rd_idx    (rd_idx),
      .rd_word   (rd_word),
      .cnt       (cnt),
      .wr        (wr),
      .rb_push   (rb_push),
      .rb_word   (rb_word),
      .scan_done (scan_done),
      .seq_done  (seq_done)
   );

   // Holds at most one LP worth of rolled-back entries
   rollback_fifo u_rb_fifo (
      .clk    (clk),
      .arst_n (arst_n),
      .push   (rb_push),
      .din    (rb_word),
      .pop    (rb_pop),
      .head   (rb_head),
      .empty  (rb_empty)
   );

   msg_sequencer u_seq (
      .clk       (clk),
      .arst_n    (arst_n),
      .scan_done (scan_done),
      .head      (rb_head),
      .empty     (rb_empty),
      .pop       (rb_pop),
      .msg_out   (msg_out),
      .seq_done  (seq_done)
   );

endmodule

// File: sim/phold_properties.sv
`include "phold_defines.svh"

module phold_properties import phold_pkg::*; (
   input logic     clk,
   input logic     arst_n,
   input msg_out_t msg_out,
   input logic     ready
);

   int fail_cnt = 0;  // Read by the testbench at the end of the run

   // Core accepts nothing while the sequencer is talking
   ready_excl: assert property (@(posedge clk) disable iff (!arst_n)
      !(ready && msg_out.valid))
      else begin
         fail_cnt++;
         $error("ready and msg_out valid high in the same cycle");
      end

   ready_after_rst: assert property (@(posedge clk) $rose(arst_n) |=> ready)
      else begin
         fail_cnt++;
         $error("ready low one cycle after reset release");
      end

   // Upper message bits are reserved
   pad_zero: assert property (@(posedge clk) disable iff (!arst_n)
      msg_out.valid |-> (msg_out.msg.pad == '0))
      else begin
         fail_cnt++;
         $error("msg_out bits 31:20 not zero on a valid message");
      end

endmodule

bind phold_core phold_properties u_props (
   .clk     (clk),
   .arst_n  (arst_n),
   .msg_out (msg_out),
   .ready   (ready)
);

// File: sim/phold_checker.sv
`include "phold_defines.svh"

module phold_checker import phold_pkg::*; (
   input logic     clk,
   input logic     arst_n,
   input evt_in_t  evt_in,
   input msg_out_t msg_out,
   input logic     ready
);

   localparam int NLP   = `PHOLD_NLP;
   localparam int DEPTH = `PHOLD_HIST_DEPTH;
   localparam int TW    = `PHOLD_TW;

   hist_entry_t hist [NLP][DEPTH];  // Each LP history in stored order
   int          hcnt [NLP];
   evt_msg_t    exp_q [$];
   logic        ready_q;
   logic        acc_q;  // Event accepted at the previous edge
   int          n_cmp = 0;
   int          n_mismatch = 0;
   int          n_protocol = 0;

   initial begin
      for (int i = 0; i < NLP; i++) begin
         hcnt[i] = 0;
      end
   end

   // Expected messages for one accepted event, history model updated in place
   function automatic void phold_ref(input evt_in_t e);
      hist_entry_t             kept [DEPTH];
      hist_entry_t             rb [DEPTH];
      hist_entry_t             h;
      evt_msg_t                main_m;
      evt_msg_t                m;
      int                      nk;
      int                      nrb;
      int                      lp;
      logic                    disc;
      logic [`PHOLD_OFS_W-1:0] ofs;
      nk            = 0;
      nrb           = 0;
      disc          = 1'b0;
      lp            = int'(e.msg.lp);
      main_m        = '0;
      main_m.cancel = 1'b1;  // Null message by default
      for (int i = 0; i < hcnt[lp]; i++) begin
         h = hist[lp][i];
         if (h.ts < e.gvt) begin
            continue;  // Below gvt, dropped silently
         end
         if (h.cancel != e.msg.cancel && h.ts == e.msg.ts && !disc) begin
            disc = 1'b1;
            if (e.msg.cancel) begin
               main_m.lp = h.target;
               main_m.ts = h.ts + TW'(h.offset);
            end
         end else if (!e.msg.cancel && !h.cancel && h.ts > e.msg.ts) begin
            rb[nrb] = h;  // Straggler forces a rollback
            nrb++;
         end else begin
            kept[nk] = h;
            nk++;
         end
      end
      if (!e.msg.cancel && !disc) begin
         ofs       = 8'(`PHOLD_MIN_GAP) + 8'(e.rnd[4:0]);
         main_m    = '0;
         main_m.lp = e.rnd[7:5];
         main_m.ts = e.msg.ts + TW'(ofs);
         if (nk < DEPTH) begin
            h        = '0;
            h.target = e.rnd[7:5];
            h.offset = ofs;
            h.lp     = e.msg.lp;
            h.ts     = e.msg.ts;
            kept[nk] = h;
            nk++;
         end
      end
      for (int i = 0; i < nk; i++) begin
         hist[lp][i] = kept[i];
      end
      hcnt[lp] = nk;
      exp_q.push_back(main_m);
      for (int i = 0; i < nrb; i++) begin
         m        = '0;
         m.cancel = 1'b1;
         m.lp     = rb[i].target;
         m.ts     = rb[i].ts + TW'(rb[i].offset);
         exp_q.push_back(m);
         m    = '0;
         m.lp = rb[i].lp;
         m.ts = rb[i].ts;
         exp_q.push_back(m);
      end
   endfunction

   always @(posedge clk or negedge arst_n) begin : compare
      evt_msg_t exp_m;
      if (!arst_n) begin
         ready_q <= 1'b1;
         acc_q   <= 1'b0;
      end else begin
         if (acc_q && ready) begin
            $display("Core stayed ready in the cycle after it accepted an event");
            n_protocol++;
         end
         if (ready && !ready_q && exp_q.size() != 0) begin
            $display("Event finished with %0d expected messages never sent", exp_q.size());
            n_protocol++;
            exp_q.delete();
         end
         if (msg_out.valid) begin
            if (exp_q.size() == 0) begin
               $display("Extra message %h on msg_out with none expected", msg_out.msg);
               n_protocol++;
            end else begin
               exp_m = exp_q.pop_front();
               n_cmp++;
               if (msg_out.msg !== exp_m) begin
                  $display("error msg_out expected %h actual %h", exp_m, msg_out.msg);
                  n_mismatch++;
               end
            end
         end
         if (evt_in.valid && ready) begin
            phold_ref(evt_in);  // Same acceptance rule as the core
         end
         ready_q <= ready;
         acc_q   <= evt_in.valid && ready;
      end
   end

endmodule

// File: sim/phold_tb.sv
`include "phold_defines.svh"

module phold_tb import phold_pkg::*; ();

   localparam int N_DIRECTED = 10;
   localparam int N_RANDOM   = 300;
   localparam int TIMEOUT    = (N_DIRECTED + N_RANDOM) * 80 * 4;

   logic                 clk = 1'b0;
   logic                 arst_n;
   evt_in_t              evt_in;
   msg_out_t             msg_out;
   logic                 ready;
   integer               seed = 32'h27;
   logic [`PHOLD_TW-1:0] gvt;
   logic [`PHOLD_TW-1:0] last_ts [`PHOLD_NLP];  // Last regular time sent per LP
   int                   n_err;

   always #2 clk = ~clk;

   phold_core DUT (
      .clk     (clk),
      .arst_n  (arst_n),
      .evt_in  (evt_in),
      .msg_out (msg_out),
      .ready   (ready)
   );

   phold_checker u_chk (
      .clk     (clk),
      .arst_n  (arst_n),
      .evt_in  (DUT.evt_in),
      .msg_out (DUT.msg_out),
      .ready   (DUT.ready)
   );

   // One-cycle strobe while ready, then wait for the core to finish
   task automatic send_event(input logic cancel, input int lp, input int ts,
                             input int g, input logic [7:0] r);
      @(negedge clk);
      while (!ready) @(negedge clk);
      evt_in            = '0;
      evt_in.valid      = 1'b1;
      evt_in.msg.cancel = cancel;
      evt_in.msg.lp     = lp[`PHOLD_NIDB-1:0];
      evt_in.msg.ts     = ts[`PHOLD_TW-1:0];
      evt_in.gvt        = g[`PHOLD_TW-1:0];
      evt_in.rnd        = r;
      @(negedge clk);
      evt_in.valid = 1'b0;
      while (!ready) @(negedge clk);
   endtask

   task automatic run_random(input int n);
      logic [31:0] r;
      int          lp;
      int          ts;
      for (int i = 0; i < n; i++) begin
         r  = $random(seed);
         lp = int'(r[2:0]);
         ts = int'(gvt) + int'(r[13:8]);
         if (r[5:4] == 2'd0) begin
            send_event(1'b1, lp, int'(last_ts[lp]), int'(gvt), r[23:16]);  // Often a hit
         end else if (r[5:4] == 2'd1) begin
            send_event(1'b1, lp, ts, int'(gvt), r[23:16]);
         end else begin
            last_ts[lp] = ts[`PHOLD_TW-1:0];
            send_event(1'b0, lp, ts, int'(gvt), r[23:16]);
         end
         gvt = gvt + 16'(r[26]);  // Slow gvt advance
      end
   endtask

   initial begin : watchdog
      #(TIMEOUT);
      $display("Timeout after %0d time units, the core stopped answering", TIMEOUT);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      evt_in = '0;
      arst_n = 1'b0;
      gvt    = '0;
      for (int i = 0; i < `PHOLD_NLP; i++) begin
         last_ts[i] = '0;
      end
      repeat (2) @(negedge clk);
      arst_n = 1'b1;
      repeat (2) @(negedge clk);

      send_event(1'b0, 1, 100, 0, 8'hA3);  // Empty LP, new event only
      send_event(1'b1, 1, 100, 0, 8'h00);  // Hits the stored entry
      send_event(1'b0, 1, 50, 0, 8'h47);   // Nothing left to roll back
      send_event(1'b0, 2, 200, 0, 8'h12);
      send_event(1'b0, 2, 210, 0, 8'hE9);
      send_event(1'b0, 2, 150, 0, 8'h5C);  // Two rollback pairs
      send_event(1'b0, 3, 300, 0, 8'h21);
      send_event(1'b0, 3, 310, 0, 8'h9F);
      send_event(1'b0, 3, 250, 400, 8'h64);  // Entries expired under gvt
      send_event(1'b1, 4, 77, 0, 8'hFF);     // Unmatched, null message

      run_random(N_RANDOM);
      repeat (2) @(posedge clk);  // Checker sees the final ready edge

      n_err = u_chk.n_mismatch + u_chk.n_protocol + DUT.u_props.fail_cnt;
      $display("Compared %0d messages: %0d mismatches, %0d protocol errors, %0d assertion failures",
               u_chk.n_cmp, u_chk.n_mismatch, u_chk.n_protocol, DUT.u_props.fail_cnt);
      if (n_err == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// File: flist.f
+incdir+design
design/phold_pkg.sv
design/history_store.sv
design/history_filter.sv
design/rollback_fifo.sv
design/msg_sequencer.sv
design/phold_core.sv
sim/phold_properties.sv
sim/phold_checker.sv
sim/phold_tb.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir build.log sim.log
verilator --binary --assert -Wno-fatal --top-module phold_tb -f flist.f -o phold_sim \
   > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/phold_sim > sim.log 2>&1
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log || exit 1
exit 0
